/* build.f */
rtl/sched_pkg.sv
rtl/rename_table.sv
rtl/operand_stage.sv
rtl/reorder_window.sv
rtl/dispatch_stage.sv
rtl/sched_top.sv
verif/sched_sva.sv
verif/sched_tb.sv

/* rtl/dispatch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage import sched_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   flush,
    input  logic [WINDOW_SIZE-1:0] ready_vec,
    input  exec_req_t              entry_req [WINDOW_SIZE],
    input  logic                   exec_done,
    output logic                   take,
    output tag_t                   take_tag,
    output logic                   done_valid,
    output logic                   exec_valid,
    output exec_req_t              exec_req
);

    // heap-ordered tree with node 1 as the root and leaves at WINDOW_SIZE + slot
    logic [2*WINDOW_SIZE-1:1] node_v;
    tag_t                     node_id [1:2*WINDOW_SIZE-1];

    genvar n;
    generate
        for (n = WINDOW_SIZE; n < 2*WINDOW_SIZE; n++) begin : g_leaf
            assign node_v[n]  = ready_vec[n-WINDOW_SIZE];
            assign node_id[n] = tag_t'(n - WINDOW_SIZE);
        end
        for (n = 1; n < WINDOW_SIZE; n++) begin : g_node
            assign node_v[n]  = node_v[2*n] || node_v[2*n+1];
            assign node_id[n] = node_v[2*n] ? node_id[2*n] : node_id[2*n+1]; // left wins
        end
    endgenerate

    assign done_valid = exec_valid && exec_done;
    assign take       = node_v[1] && (!exec_valid || exec_done);  // port idle or finishing
    assign take_tag   = node_id[1];

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            exec_valid <= 1'b0;
        end else if (take) begin
            exec_valid <= 1'b1;
        end else if (done_valid) begin
            exec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            exec_req <= entry_req[take_tag];
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_stage import sched_pkg::*; (
    input  issue_req_t issue_req,
    input  word_t      rf_rs1_val,
    input  word_t      rf_rs2_val,
    input  logic       rs1_busy,
    input  logic       rs2_busy,
    input  tag_t       rs1_tag,
    input  tag_t       rs2_tag,
    input  logic       done_valid,
    input  exec_resp_t done_resp,
    input  logic       prod1_done,
    input  logic       prod2_done,
    input  word_t      prod1_val,
    input  word_t      prod2_val,
    output word_t      op1_val,
    output word_t      op2_val,
    output logic       op1_ready,
    output logic       op2_ready
);

    typedef struct packed {
        logic  ready;
        word_t value;
    } operand_t;

    operand_t src1;
    operand_t src2;

    function automatic operand_t resolve(input reg_idx_t idx, input logic busy,
                                         input tag_t tag, input logic bypass_en,
                                         input exec_resp_t bypass, input logic prod_done,
                                         input word_t prod_val, input word_t rf_val);
        operand_t op;
        op.ready = 1'b1;
        op.value = rf_val;                  // unrenamed register reads the register file
        if (idx == '0) begin
            op.value = '0;
        end else if (busy && bypass_en && (bypass.tag == tag)) begin
            op.value = bypass.result;       // producer completes this cycle
        end else if (busy && prod_done) begin
            op.value = prod_val;
        end else if (busy) begin
            op.ready = 1'b0;                // wait for the broadcast of tag
            op.value = '0;
        end
        return op;
    endfunction

    always_comb begin
        src1 = resolve(issue_req.rs1, rs1_busy, rs1_tag, done_valid, done_resp,
                       prod1_done, prod1_val, rf_rs1_val);
        src2 = resolve(issue_req.rs2, rs2_busy, rs2_tag, done_valid, done_resp,
                       prod2_done, prod2_val, rf_rs2_val);
    end

    assign op1_val   = src1.value;
    assign op1_ready = src1.ready;
    assign op2_val   = src2.value;
    assign op2_ready = src2.ready;

endmodule

`default_nettype wire

/* rtl/rename_table.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_table import sched_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     flush,
    input  reg_idx_t lookup_rs1,
    input  reg_idx_t lookup_rs2,
    output logic     rs1_busy,
    output logic     rs2_busy,
    output tag_t     rs1_tag,
    output tag_t     rs2_tag,
    input  logic     alloc_en,
    input  reg_idx_t alloc_rd,
    input  tag_t     alloc_tag,
    input  logic     release_en,
    input  reg_idx_t release_rd,
    input  tag_t     release_tag
);

    logic [NUM_REGS-1:0] busy;          // bit 0 stays clear because x0 is never renamed
    tag_t                producer [NUM_REGS];
    logic                alloc_hit;
    logic                release_hit;

    assign rs1_busy = busy[lookup_rs1];
    assign rs2_busy = busy[lookup_rs2];
    assign rs1_tag  = producer[lookup_rs1];
    assign rs2_tag  = producer[lookup_rs2];

    assign alloc_hit = alloc_en && (alloc_rd != '0);

    // a younger writer of the same register keeps it busy
    assign release_hit = release_en && busy[release_rd]
                         && (producer[release_rd] == release_tag)
                         && !(alloc_hit && (alloc_rd == release_rd));

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            busy <= '0;
        end else begin
            if (release_hit) begin
                busy[release_rd] <= 1'b0;
            end
            if (alloc_hit) begin
                busy[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc_hit) begin
            producer[alloc_rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

/* rtl/reorder_window.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_window import sched_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   issue_valid,
    input  issue_req_t             issue_req,
    output logic                   issue_ready,
    output logic                   alloc_en,
    output tag_t                   alloc_tag,
    input  word_t                  op1_val,
    input  word_t                  op2_val,
    input  logic                   op1_ready,
    input  logic                   op2_ready,
    input  tag_t                   rs1_tag,
    input  tag_t                   rs2_tag,
    output logic                   prod1_done,
    output logic                   prod2_done,
    output word_t                  prod1_val,
    output word_t                  prod2_val,
    input  logic                   done_valid,
    input  exec_resp_t             done_resp,
    input  logic                   take,
    input  tag_t                   take_tag,
    output logic [WINDOW_SIZE-1:0] ready_vec,
    output exec_req_t              entry_req [WINDOW_SIZE],
    output logic                   rf_we,
    output commit_t                rf_commit,
    output logic                   flush,
    output word_t                  redirect_pc,
    output logic                   release_en,
    output reg_idx_t               release_rd,
    output tag_t                   release_tag
);

    entry_state_t           state    [WINDOW_SIZE];
    word_t                  pred_pc  [WINDOW_SIZE];
    word_t                  next_pc  [WINDOW_SIZE];
    word_t                  result   [WINDOW_SIZE];
    tag_t                   src1_tag [WINDOW_SIZE];
    tag_t                   src2_tag [WINDOW_SIZE];
    logic [WINDOW_SIZE-1:0] src1_rdy;
    logic [WINDOW_SIZE-1:0] src2_rdy;
    tag_t                   head;
    tag_t                   tail;
    logic [TAG_BITS:0]      count;      // 0 .. WINDOW_SIZE
    logic                   head_done;

    assign issue_ready = (count < WINDOW_SIZE);
    assign alloc_en    = issue_valid && issue_ready;
    assign alloc_tag   = tail;

    assign prod1_done = (state[rs1_tag] == st_done);
    assign prod2_done = (state[rs2_tag] == st_done);
    assign prod1_val  = result[rs1_tag];
    assign prod2_val  = result[rs2_tag];

    always_comb begin
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            ready_vec[i] = (state[i] == st_waiting) && src1_rdy[i] && src2_rdy[i];
        end
    end

    assign head_done       = (count != '0) && (state[head] == st_done);
    assign rf_we           = head_done;
    assign rf_commit.rd    = entry_req[head].rd;
    assign rf_commit.value = result[head];
    assign flush           = head_done && (next_pc[head] != pred_pc[head]);
    assign redirect_pc     = next_pc[head];
    assign release_en      = head_done;
    assign release_rd      = entry_req[head].rd;
    assign release_tag     = head;

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            for (int i = 0; i < WINDOW_SIZE; i++) begin
                state[i] <= st_empty;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (head_done) begin
                state[head] <= st_empty;
                head        <= head + 1'b1;
            end
            if (alloc_en) begin
                state[tail] <= st_waiting;
                tail        <= tail + 1'b1;
            end
            if (take) begin
                state[take_tag] <= st_executing;
            end
            if (done_valid) begin
                state[done_resp.tag] <= st_done;
            end
            count <= count + (TAG_BITS+1)'(alloc_en) - (TAG_BITS+1)'(head_done);
        end
    end

    always_ff @(posedge clk_in) begin
        if (done_valid) begin
            result[done_resp.tag]  <= done_resp.result;
            next_pc[done_resp.tag] <= done_resp.next_pc;
            for (int i = 0; i < WINDOW_SIZE; i++) begin  // wakeup broadcast
                if (state[i] == st_waiting && !src1_rdy[i] && src1_tag[i] == done_resp.tag) begin
                    src1_rdy[i]          <= 1'b1;
                    entry_req[i].rs1_val <= done_resp.result;
                end
                if (state[i] == st_waiting && !src2_rdy[i] && src2_tag[i] == done_resp.tag) begin
                    src2_rdy[i]          <= 1'b1;
                    entry_req[i].rs2_val <= done_resp.result;
                end
            end
        end
        if (alloc_en) begin
            entry_req[tail] <= '{tag: tail, opcode: issue_req.opcode,
                                 funct3: issue_req.funct3, funct7: issue_req.funct7,
                                 imm: issue_req.imm, shamt: issue_req.shamt,
                                 rs1_val: op1_val, rs2_val: op2_val,
                                 rd: issue_req.rd, pc: issue_req.pc};
            pred_pc[tail]  <= issue_req.pred_pc;
            src1_tag[tail] <= rs1_tag;
            src2_tag[tail] <= rs2_tag;
            src1_rdy[tail] <= op1_ready;
            src2_rdy[tail] <= op2_ready;
        end
    end

endmodule

`default_nettype wire

/* rtl/sched_pkg.sv */
`default_nettype none

package sched_pkg;

    localparam int WINDOW_SIZE = 8;
    localparam int TAG_BITS    = 3;
    localparam int NUM_REGS    = 32;

    typedef logic [31:0]         word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;   // window slot number

    typedef enum logic [1:0] {
        st_empty,
        st_waiting,
        st_executing,
        st_done
    } entry_state_t;

    typedef struct packed {
        word_t      pc;
        word_t      pred_pc;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;
        logic [5:0] shamt;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
    } issue_req_t;

    typedef struct packed {
        tag_t       tag;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;
        logic [5:0] shamt;
        word_t      rs1_val;
        word_t      rs2_val;
        reg_idx_t   rd;
        word_t      pc;
    } exec_req_t;

    typedef struct packed {
        tag_t  tag;
        word_t result;
        word_t next_pc;   // resolved next pc that commit compares with pred_pc
    } exec_resp_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } commit_t;

endpackage

`default_nettype wire

/* rtl/sched_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sched_top import sched_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       issue_valid,
    input  issue_req_t issue_req,
    output logic       issue_ready,
    output reg_idx_t   rf_rs1_idx,
    output reg_idx_t   rf_rs2_idx,
    input  word_t      rf_rs1_val,
    input  word_t      rf_rs2_val,
    output logic       exec_valid,
    output exec_req_t  exec_req,
    input  logic       exec_done,
    input  exec_resp_t exec_resp,
    output logic       rf_we,
    output commit_t    rf_commit,
    output logic       flush,
    output word_t      redirect_pc
);

    logic                   rs1_busy;
    logic                   rs2_busy;
    tag_t                   rs1_tag;
    tag_t                   rs2_tag;
    logic                   alloc_en;
    tag_t                   alloc_tag;
    logic                   release_en;
    reg_idx_t               release_rd;
    tag_t                   release_tag;
    logic                   done_valid;
    logic                   prod1_done;
    logic                   prod2_done;
    word_t                  prod1_val;
    word_t                  prod2_val;
    word_t                  op1_val;
    word_t                  op2_val;
    logic                   op1_ready;
    logic                   op2_ready;
    logic                   take;
    tag_t                   take_tag;
    logic [WINDOW_SIZE-1:0] ready_vec;
    exec_req_t              entry_req [WINDOW_SIZE];

    assign rf_rs1_idx = issue_req.rs1;
    assign rf_rs2_idx = issue_req.rs2;

    rename_table rename_i (
        .lookup_rs1 (issue_req.rs1),
        .lookup_rs2 (issue_req.rs2),
        .alloc_rd   (issue_req.rd),
        .*
    );

    operand_stage operand_i (
        .done_resp (exec_resp),
        .*
    );

    reorder_window window_i (
        .done_resp (exec_resp),
        .*
    );

    dispatch_stage dispatch_i (.*);

endmodule

`default_nettype wire

/* verif/sched_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module sched_sva import sched_pkg::*; (
    input logic      clk_in,
    input logic      rst_in,
    input logic      exec_valid,
    input logic      exec_done,
    input exec_req_t exec_req,
    input logic      flush,
    input logic      rf_we,
    input logic      issue_ready
);

    int fail_cnt = 0;

    // executor may look at the request on any cycle until it answers
    req_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        exec_valid && !exec_done |=> $stable(exec_req))
        else begin
            $error("exec_req changed while waiting for exec_done");
            fail_cnt++;
        end

    flush_commits: assert property (@(posedge clk_in) disable iff (rst_in)
        flush |-> rf_we)
        else begin
            $error("flush raised without a register write");
            fail_cnt++;
        end

    ready_after_reset: assert property (@(posedge clk_in) $fell(rst_in) |-> issue_ready)
        else begin
            $error("issue_ready low on the first cycle after reset");
            fail_cnt++;
        end

endmodule

bind sched_top sched_sva sva_i (.*);

`default_nettype wire

/* verif/sched_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sched_tb import sched_pkg::*;;

    logic       clk_in;
    logic       rst_in;
    logic       issue_valid;
    issue_req_t issue_req;
    logic       issue_ready;
    reg_idx_t   rf_rs1_idx;
    reg_idx_t   rf_rs2_idx;
    word_t      rf_rs1_val;
    word_t      rf_rs2_val;
    logic       exec_valid;
    exec_req_t  exec_req;
    logic       exec_done;
    exec_resp_t exec_resp;
    logic       rf_we;
    commit_t    rf_commit;
    logic       flush;
    word_t      redirect_pc;

    word_t     regs [NUM_REGS];     // register file model
    word_t     arch [NUM_REGS];     // expected architectural state in program order
    commit_t   exp_commits [$];
    exec_req_t exp_exec [64];       // indexed by instruction number
    int        seq = 0;
    int        errors = 0;
    int        checks = 0;
    int        commit_cnt = 0;
    int        flush_cnt = 0;
    tag_t      slot = '0;           // next window slot the DUT hands out
    word_t     last_redirect;
    logic      hold_exec;
    int        fixed_delay;         // negative picks a random delay
    word_t     bad_pc;
    word_t     bad_next;
    logic      pending;
    int        wait_cnt;
    integer    seed = 32'hac4a;

    sched_top dut_i (.*);

    assign rf_rs1_val = regs[rf_rs1_idx];
    assign rf_rs2_val = regs[rf_rs2_idx];

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        if (rf_we && rf_commit.rd != '0) begin
            regs[rf_commit.rd] <= rf_commit.value;
        end
    end

    // executor answers result = rs1 + imm after a delay
    always @(posedge clk_in) begin
        if (rst_in || flush) begin
            exec_done <= 1'b0;
            pending = 1'b0;
        end else if (exec_done) begin
            exec_done <= 1'b0;
            pending = 1'b0;
        end else if (exec_valid && !hold_exec) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = (fixed_delay >= 0) ? fixed_delay : ($unsigned($random(seed)) % 4);
            end
            if (wait_cnt == 0) begin
                exec_done <= 1'b1;
                exec_resp <= '{tag: exec_req.tag, result: exec_req.rs1_val + exec_req.imm,
                               next_pc: (exec_req.pc == bad_pc) ? bad_next : exec_req.pc + 4};
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk_in) begin
        if (!rst_in && rf_we) begin
            commit_cnt++;
            if (exp_commits.size() == 0) begin
                errors++;
                $display("%0t: unexpected commit to register %0d", $time, rf_commit.rd);
            end else begin
                check_commit(rf_commit, exp_commits.pop_front(), "commit");
            end
        end
        if (!rst_in && flush) begin
            flush_cnt++;
            last_redirect = redirect_pc;
            slot          = '0;
        end
        if (!rst_in && exec_valid && exec_done) begin
            check_exec(exec_req, exp_exec[(exec_req.pc - 32'h1000) >> 2], "dispatch");
        end
    end

    task automatic check_commit(input commit_t got, input commit_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s rd %0d value %h, expected rd %0d value %h", $time, what,
                     got.rd, got.value, exp.rd, exp.value);
        end
    endtask

    task automatic check_exec(input exec_req_t got, input exec_req_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s pc %h tag %0d rs1_val %h, expected pc %h tag %0d rs1_val %h",
                     $time, what, got.pc, got.tag, got.rs1_val, exp.pc, exp.tag, exp.rs1_val);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        errors = errors + dut_i.sva_i.fail_cnt;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic give_up(input string why);
        errors++;
        $display("%0t: %s", $time, why);
        finish_run();
    endtask

    task automatic report_test(input string name, input int e0);
        $display("%0t: test %s finished with %0d errors", $time, name, errors - e0);
    endtask

    // keep clear marks a wrong-path instruction that must never commit
    task automatic issue(input reg_idx_t rd, input reg_idx_t rs1, input word_t imm,
                         input bit keep);
        word_t    pc;
        word_t    value;
        reg_idx_t rs2;
        commit_t  c;
        int       t;
        pc    = 32'h1000 + (seq << 2);
        value = arch[rs1] + imm;
        rs2   = rs1 + 5'd1;
        @(posedge clk_in);
        issue_valid <= 1'b1;
        issue_req   <= '{pc: pc, pred_pc: pc + 4, opcode: 7'h13, funct3: 3'd0, funct7: 7'd0,
                         imm: imm, shamt: 6'd0, rs1: rs1, rs2: rs2, rd: rd};
        t = 0;
        do begin
            @(posedge clk_in);
            t++;
        end while (!issue_ready && t < 50);
        issue_valid <= 1'b0;
        if (!issue_ready) give_up("timeout waiting for the window to accept an issue");
        exp_exec[seq] = '{tag: slot, opcode: 7'h13, funct3: 3'd0, funct7: 7'd0, imm: imm,
                          shamt: 6'd0, rs1_val: arch[rs1], rs2_val: arch[rs2], rd: rd, pc: pc};
        slot++;
        seq++;
        if (keep) begin
            c = '{rd: rd, value: value};
            exp_commits.push_back(c);
            if (rd != '0) arch[rd] = value;
        end
    endtask

    task automatic wait_idle(input string what);
        int t;
        t = 0;
        do begin
            @(negedge clk_in);
            t++;
        end while (exp_commits.size() != 0 && t < 300);
        if (exp_commits.size() != 0) give_up({"timeout waiting for ", what});
    endtask

    task automatic commit_in_order();
        int e0;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            issue(reg_idx_t'(10 + i), reg_idx_t'(1 + i), word_t'(32'h10 * i + 3), 1'b1);
        end
        wait_idle("in-order commits");
        report_test("in_order_commit", e0);
    endtask

    // consumer lands before, on and after the producer's completion edge
    task automatic chain_dependents();
        int e0;
        e0 = errors;
        fixed_delay <= 2;
        for (int gap = 0; gap < 6; gap++) begin
            issue(5'd5, 5'd2, word_t'(gap + 1), 1'b1);
            repeat (gap) @(posedge clk_in);
            issue(5'd6, 5'd5, 32'h40, 1'b1);
            wait_idle("dependent chain");
        end
        fixed_delay <= -1;
        report_test("dependent_chain", e0);
    endtask

    task automatic read_zero_and_rf();
        int e0;
        e0 = errors;
        issue(5'd7, 5'd0, 32'h55, 1'b1);
        issue(5'd8, 5'd20, 32'h66, 1'b1);
        wait_idle("zero register commits");
        report_test("zero_and_unrenamed", e0);
    endtask

    task automatic fill_window();
        int e0;
        int c0;
        int t;
        e0 = errors;
        hold_exec <= 1'b1;
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            issue(reg_idx_t'(16 + i), reg_idx_t'(24 + i % 4), word_t'(i), 1'b1);
        end
        @(negedge clk_in);
        check_word(word_t'(issue_ready), '0, "issue_ready with a full window");
        c0 = commit_cnt;
        @(posedge clk_in);
        hold_exec <= 1'b0;
        t = 0;
        do begin
            @(negedge clk_in);
            t++;
        end while (!issue_ready && t < 100);
        if (!issue_ready) give_up("issue_ready never returned after the executor resumed");
        check_word(word_t'(commit_cnt - c0), 32'd1, "commits before issue_ready returned");
        wait_idle("full window drain");
        report_test("full_window", e0);
    endtask

    task automatic recover_from_flush();
        int e0;
        int f0;
        int t;
        e0 = errors;
        f0 = flush_cnt;
        fixed_delay <= 6;                   // keeps the younger ones behind the branch
        bad_pc      <= 32'h1000 + (seq << 2);
        issue(5'd9, 5'd3, 32'h77, 1'b1);
        issue(5'd11, 5'd4, 32'h88, 1'b0);
        issue(5'd12, 5'd9, 32'h99, 1'b0);
        t = 0;
        do begin
            @(negedge clk_in);
            t++;
        end while (flush_cnt == f0 && t < 100);
        if (flush_cnt == f0) give_up("no flush after a wrong next pc");
        check_word(last_redirect, bad_next, "redirect_pc");
        fixed_delay <= -1;
        bad_pc      <= '1;
        issue(5'd13, 5'd9, 32'h5, 1'b1);
        issue(5'd14, 5'd11, 32'h6, 1'b1);
        wait_idle("commits after the flush");
        check_word(word_t'(flush_cnt - f0), 32'd1, "flush count");
        report_test("misprediction", e0);
    endtask

    initial begin
        rst_in      = 1'b1;
        issue_valid = 1'b0;
        issue_req   = '0;
        exec_done   = 1'b0;
        exec_resp   = '0;
        hold_exec   = 1'b0;
        pending     = 1'b0;
        wait_cnt    = 0;
        fixed_delay = -1;
        bad_pc      = '1;
        bad_next    = 32'h0000_8000;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = (i == 0) ? '0 : 32'h1000_0000 + i * 32'h0101;
            arch[i] = regs[i];
        end
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;
        commit_in_order();
        chain_dependents();
        read_zero_and_rf();
        fill_window();
        recover_from_flush();
        finish_run();
    end

endmodule

`default_nettype wire
